// ==== stationPkg.sv ====
// ==============================
// Shared widths, depths and types for the operand-capture issue path
// Every RTL block and the testbench pull these in by wildcard import
// ==============================

package stationPkg;

	// ==============================
	// Datapath widths
	// ==============================

	// Width of an operand or a result value
	localparam int ValueWidth = 16;

	// Operand or result value, arithmetic wraps modulo 2^16
	typedef logic [ValueWidth-1:0] value_t;

	// Physical register number, register 0 always reads as zero
	typedef logic [5:0] pregno_t;

	// Reorder-buffer id that tags an operation through to its result
	typedef logic [3:0] robNdx_t;

	// ==============================
	// Structure sizes
	// ==============================

	// Lanes on the register read-port bus
	localparam int NumPorts = 4;

	// Entries held in the operand station
	localparam int StationDepth = 4;

	// Source operands per operation (A, B and C)
	localparam int NumSrcs = 3;

	// Index of one station entry
	typedef logic [$clog2(StationDepth)-1:0] slot_t;

	// Credit count, wide enough to hold StationDepth itself
	typedef logic [2:0] credit_t;

	// Cycles from an issue beat to the matching result
	localparam int ExecLatency = 2;

	// ==============================
	// Operation codes
	// ==============================

	// MAC gives a*b+c, MUL gives a*b and ADD gives a+b
	typedef enum logic [1:0] {
		OP_MAC = 2'd0,
		OP_MUL = 2'd1,
		OP_ADD = 2'd2
	} opcode_t;

endpackage

// ==== opLink.sv ====
// ==============================
// Link from the dispatcher to the operand station
// Carries one operation per valid beat and returns one credit per freed entry
// ==============================
`timescale 1ns/1ps

interface opLink import stationPkg::*; ();

	// One dispatched operation, qualified by valid
	logic valid;
	robNdx_t id;
	opcode_t opcode;
	pregno_t srcA;
	pregno_t srcB;
	pregno_t srcC;
	pregno_t dest;

	// Single-cycle pulse for each entry that leaves the station
	logic creditRet;

	// The dispatcher only raises valid while it holds a credit
	modport disp (
		output valid, id, opcode, srcA, srcB, srcC, dest,
		input creditRet
	);

	// The station takes every valid beat, there is no ready
	modport stn (
		input valid, id, opcode, srcA, srcB, srcC, dest,
		output creditRet
	);

endinterface

// ==== issueLink.sv ====
// ==============================
// Link from the operand station to the execute unit
// Each valid beat is one operation with all operand values captured
// ==============================
`timescale 1ns/1ps

interface issueLink import stationPkg::*; ();

	// Issued operation with its operand values
	logic valid;
	robNdx_t id;
	opcode_t opcode;
	value_t argA;
	value_t argB;
	value_t argC;
	pregno_t dest;

	// Station side drives everything
	modport stn (
		output valid, id, opcode, argA, argB, argC, dest
	);

	// The execute unit accepts every beat
	modport exec (
		input valid, id, opcode, argA, argB, argC, dest
	);

endinterface

// ==== opDispatch.sv ====
// ==============================
// Dispatcher in front of the operand station
// Registers accepted operations onto the link and keeps the credit count
// opReady is high while at least one station entry is known to be free
// ==============================
`timescale 1ns/1ps

module opDispatch import stationPkg::*; (
	input logic clk,
	input logic rst,
	input logic opValid,
	input robNdx_t opId,
	input opcode_t opOpcode,
	input pregno_t opSrcA,
	input pregno_t opSrcB,
	input pregno_t opSrcC,
	input pregno_t opDest,
	output logic opReady,
	opLink.disp link
);

	// Credits currently held, one per free station entry
	credit_t credits;
	credit_t nextCredits;

	// Upstream handshake completes on this edge
	logic accept;

	assign accept = opValid && opReady;

	// Next count covers an accept and a return landing on the same edge
	always_comb begin
		nextCredits = credits;
		if (link.creditRet)
			nextCredits = nextCredits + credit_t'(1);
		if (accept)
			nextCredits = nextCredits - credit_t'(1);
	end

	// ==============================
	// Credit counter and link valid
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= credit_t'(StationDepth);
			opReady <= 1'b1;
			link.valid <= 1'b0;
		end else begin
			credits <= nextCredits;
			// Registered so opReady tracks the counter with no extra cycle
			opReady <= (nextCredits != '0);
			link.valid <= accept;
		end
	end

	// Payload only moves on an accept and needs no reset
	always_ff @(posedge clk) begin
		if (accept) begin
			link.id <= opId;
			link.opcode <= opOpcode;
			link.srcA <= opSrcA;
			link.srcB <= opSrcB;
			link.srcC <= opSrcC;
			link.dest <= opDest;
		end
	end

	// Returns never push the count past the number of entries
	creditBound: assert property (@(posedge clk) disable iff (rst)
		credits <= credit_t'(StationDepth));

	// A beat on the link was paid for with a credit on the edge before
	validNeedsCredit: assert property (@(posedge clk) disable iff (rst)
		link.valid |-> $past(credits) != '0);

endmodule

// ==== operandStation.sv ====
// ==============================
// Operand station between dispatch and execute
// Holds operations until every source value has been seen on the read-port bus
// Issues the lowest ready entry each cycle and returns its credit
// ==============================
`timescale 1ns/1ps

module operandStation import stationPkg::*; (
	input logic clk,
	input logic rst,
	input pregno_t [NumPorts-1:0] prn,
	input logic [NumPorts-1:0] prnv,
	input value_t [NumPorts-1:0] rfo,
	opLink.stn inLink,
	issueLink.stn outLink
);

	// ==============================
	// Entry storage
	// ==============================

	// Occupied flag and per-source captured flags are the control state
	logic [StationDepth-1:0] entValid;
	logic [NumSrcs-1:0] entRdy [StationDepth];

	// Operation payload with sources ordered A, B and C
	robNdx_t entId [StationDepth];
	opcode_t entOp [StationDepth];
	pregno_t entDest [StationDepth];
	pregno_t entTag [StationDepth][NumSrcs];
	value_t entVal [StationDepth][NumSrcs];

	// Sources of the operation arriving this cycle
	pregno_t inSrc [NumSrcs];
	logic [NumSrcs-1:0] inRdy;
	value_t inVal [NumSrcs];

	// Bus hits for sources already waiting in the station
	logic [NumSrcs-1:0] capEn [StationDepth];
	value_t capVal [StationDepth][NumSrcs];

	// Write and issue selection
	logic freeFound;
	slot_t freeIdx;
	logic issueFound;
	slot_t issueIdx;

	// True when any valid lane carries this register
	function automatic logic busHit(input pregno_t tag);
		logic hit;
		hit = 1'b0;
		for (int p = 0; p < NumPorts; p++) begin
			if (prnv[p] && prn[p] == tag)
				hit = 1'b1;
		end
		return hit;
	endfunction

	// Value from the lowest-numbered matching lane
	function automatic value_t busValue(input pregno_t tag);
		value_t val;
		val = '0;
		// Walk downward so the lowest lane is the last to write
		for (int p = NumPorts - 1; p >= 0; p--) begin
			if (prnv[p] && prn[p] == tag)
				val = rfo[p];
		end
		return val;
	endfunction

	// ==============================
	// Operand snooping
	// ==============================

	// An incoming source is ready at once if it is register 0 or on the bus now
	always_comb begin
		inSrc[0] = inLink.srcA;
		inSrc[1] = inLink.srcB;
		inSrc[2] = inLink.srcC;
		for (int s = 0; s < NumSrcs; s++) begin
			if (inSrc[s] == '0) begin
				inRdy[s] = 1'b1;
				inVal[s] = '0;
			end else begin
				inRdy[s] = busHit(inSrc[s]);
				inVal[s] = busValue(inSrc[s]);
			end
		end
	end

	// Waiting sources watch the bus every cycle
	always_comb begin
		for (int i = 0; i < StationDepth; i++) begin
			for (int s = 0; s < NumSrcs; s++) begin
				capEn[i][s] = entValid[i] && !entRdy[i][s] && busHit(entTag[i][s]);
				capVal[i][s] = busValue(entTag[i][s]);
			end
		end
	end

	// Lowest free entry takes the write and lowest ready entry issues
	always_comb begin
		freeFound = 1'b0;
		freeIdx = '0;
		issueFound = 1'b0;
		issueIdx = '0;
		for (int i = StationDepth - 1; i >= 0; i--) begin
			if (!entValid[i]) begin
				freeFound = 1'b1;
				freeIdx = slot_t'(i);
			end
			if (entValid[i] && (&entRdy[i])) begin
				issueFound = 1'b1;
				issueIdx = slot_t'(i);
			end
		end
	end

	// ==============================
	// Control state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			entValid <= '0;
			for (int i = 0; i < StationDepth; i++)
				entRdy[i] <= '0;
			outLink.valid <= 1'b0;
			inLink.creditRet <= 1'b0;
		end else begin
			// The credit goes back in the same cycle as the issue beat
			outLink.valid <= issueFound;
			inLink.creditRet <= issueFound;
			for (int i = 0; i < StationDepth; i++)
				entRdy[i] <= entRdy[i] | capEn[i];
			if (issueFound)
				entValid[issueIdx] <= 1'b0;
			// Never collides with the issued entry since that one was occupied
			if (inLink.valid) begin
				entValid[freeIdx] <= 1'b1;
				entRdy[freeIdx] <= inRdy;
			end
		end
	end

	// Payload writes, captures and the issue register
	always_ff @(posedge clk) begin
		for (int i = 0; i < StationDepth; i++) begin
			for (int s = 0; s < NumSrcs; s++) begin
				if (capEn[i][s])
					entVal[i][s] <= capVal[i][s];
			end
		end
		if (inLink.valid) begin
			entId[freeIdx] <= inLink.id;
			entOp[freeIdx] <= inLink.opcode;
			entDest[freeIdx] <= inLink.dest;
			for (int s = 0; s < NumSrcs; s++) begin
				entTag[freeIdx][s] <= inSrc[s];
				entVal[freeIdx][s] <= inVal[s];
			end
		end
		if (issueFound) begin
			outLink.id <= entId[issueIdx];
			outLink.opcode <= entOp[issueIdx];
			outLink.dest <= entDest[issueIdx];
			outLink.argA <= entVal[issueIdx][0];
			outLink.argB <= entVal[issueIdx][1];
			outLink.argC <= entVal[issueIdx][2];
		end
	end

	// Dispatcher credits guarantee room for every write
	writeHasRoom: assert property (@(posedge clk) disable iff (rst)
		inLink.valid |-> freeFound);

	// An entry only leaves the station once every one of its sources was captured
	for (genvar g = 0; g < StationDepth; g++) begin : gLeave
		issueWasReady: assert property (@(posedge clk) disable iff (rst)
			$fell(entValid[g]) |-> $past(&entRdy[g]));
	end

endmodule

// ==== macExec.sv ====
// ==============================
// Two-stage integer multiply-accumulate unit
// Takes every issue beat and returns the tagged result ExecLatency cycles later
// ==============================
`timescale 1ns/1ps

module macExec import stationPkg::*; (
	input logic clk,
	input logic rst,
	issueLink.exec inLink,
	output logic resValid,
	output robNdx_t resId,
	output pregno_t resDest,
	output value_t resValue
);

	// One valid bit per stage, so two operations can be in flight
	logic [ExecLatency-1:0] validPipe;

	// Stage one registers
	robNdx_t s1Id;
	opcode_t s1Op;
	pregno_t s1Dest;
	value_t s1Prod;
	value_t s1ArgB;
	value_t s1ArgC;

	// Second operand of the stage two adder
	value_t addend;

	always_ff @(posedge clk) begin
		if (rst)
			validPipe <= '0;
		else
			validPipe <= {validPipe[ExecLatency-2:0], inLink.valid};
	end

	// ==============================
	// Stage one
	// ==============================

	// ADD passes argA through in place of the product
	always_ff @(posedge clk) begin
		if (inLink.valid) begin
			s1Id <= inLink.id;
			s1Op <= inLink.opcode;
			s1Dest <= inLink.dest;
			s1ArgB <= inLink.argB;
			s1ArgC <= inLink.argC;
			if (inLink.opcode == OP_ADD)
				s1Prod <= inLink.argA;
			else
				s1Prod <= value_t'(inLink.argA * inLink.argB);
		end
	end

	// ==============================
	// Stage two
	// ==============================

	// MUL adds nothing
	always_comb begin
		case (s1Op)
			OP_MAC: addend = s1ArgC;
			OP_ADD: addend = s1ArgB;
			default: addend = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (validPipe[0]) begin
			resId <= s1Id;
			resDest <= s1Dest;
			resValue <= s1Prod + addend;
		end
	end

	assign resValid = validPipe[ExecLatency-1];

endmodule

// ==== issueTop.sv ====
// ==============================
// Top level of the issue subsystem
// Dispatcher, operand station and multiply-accumulate unit on plain ports
// Upstream transfers on an edge where opValid and opReady are both high
// ==============================
`timescale 1ns/1ps

module issueTop import stationPkg::*; (
	input logic clk,
	input logic rst,
	// Decoded operation from upstream
	input logic opValid,
	input robNdx_t opId,
	input opcode_t opOpcode,
	input pregno_t opSrcA,
	input pregno_t opSrcB,
	input pregno_t opSrcC,
	input pregno_t opDest,
	output logic opReady,
	// Register read-port bus, one lane per port
	input pregno_t [NumPorts-1:0] prn,
	input logic [NumPorts-1:0] prnv,
	input value_t [NumPorts-1:0] rfo,
	// Results, possibly out of arrival order
	output logic resValid,
	output robNdx_t resId,
	output pregno_t resDest,
	output value_t resValue
);

	// Dispatcher to station
	opLink opBus ();

	// Station to execute unit
	issueLink issueBus ();

	opDispatch uDispatch (
		.clk(clk),
		.rst(rst),
		.opValid(opValid),
		.opId(opId),
		.opOpcode(opOpcode),
		.opSrcA(opSrcA),
		.opSrcB(opSrcB),
		.opSrcC(opSrcC),
		.opDest(opDest),
		.opReady(opReady),
		.link(opBus.disp)
	);

	operandStation uStation (
		.clk(clk),
		.rst(rst),
		.prn(prn),
		.prnv(prnv),
		.rfo(rfo),
		.inLink(opBus.stn),
		.outLink(issueBus.stn)
	);

	macExec uExec (
		.clk(clk),
		.rst(rst),
		.inLink(issueBus.exec),
		.resValid(resValid),
		.resId(resId),
		.resDest(resDest),
		.resValue(resValue)
	);

endmodule

// ==== issueTb.sv ====
// ==============================
// Random-stimulus testbench for the issue subsystem
// Models register values and checks every tagged result against a scoreboard
// Built with the Makefile and ends the run with one verdict line
// ==============================
`timescale 1ns/1ps

module issueTb import stationPkg::*; ;

	// Random operations in the main phase
	localparam int NumOps = 400;

	// About 40 cycles per operation in the worst case plus margin for the short tests
	localparam int MaxCycles = NumOps * (38 + ExecLatency) + 4000;

	logic clk;
	logic rst;
	logic opValid;
	robNdx_t opId;
	opcode_t opOpcode;
	pregno_t opSrcA;
	pregno_t opSrcB;
	pregno_t opSrcC;
	pregno_t opDest;
	logic opReady;
	pregno_t [NumPorts-1:0] prn;
	logic [NumPorts-1:0] prnv;
	value_t [NumPorts-1:0] rfo;
	logic resValid;
	robNdx_t resId;
	pregno_t resDest;
	value_t resValue;

	// ==============================
	// Model and scoreboard
	// ==============================

	// Value each register holds during the current phase
	value_t regValue [64];

	// Expected result, dest and pending flag per reorder-buffer id
	value_t expValue [16];
	pregno_t expDest [16];
	logic pending [16];

	// Ids in the order their results came out
	robNdx_t doneOrder [$];

	// Bus lanes only carry traffic while this is set
	logic busOn;
	int errorCount;
	int resultCount;
	int acceptCount;
	int cycleCount;
	int unsigned seed;

	issueTop dut (
		.clk(clk),
		.rst(rst),
		.opValid(opValid),
		.opId(opId),
		.opOpcode(opOpcode),
		.opSrcA(opSrcA),
		.opSrcB(opSrcB),
		.opSrcC(opSrcC),
		.opDest(opDest),
		.opReady(opReady),
		.prn(prn),
		.prnv(prnv),
		.rfo(rfo),
		.resValid(resValid),
		.resId(resId),
		.resDest(resDest),
		.resValue(resValue)
	);

	always #4 clk = ~clk;

	// Hard cycle limit so a stuck operation cannot hang the run
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= MaxCycles) begin
			$display("Timeout after %0d cycles with operations still outstanding", cycleCount);
			$display("Errors: %0d, results: %0d", errorCount, resultCount);
			$display("Test failures found");
			$finish;
		end
	end

	// Arithmetic wraps at 16 bits and register 0 is always zero in the model
	function automatic value_t calcResult(input opcode_t op, input pregno_t a,
			input pregno_t b, input pregno_t c);
		value_t va;
		value_t vb;
		value_t vc;
		value_t r;
		va = regValue[a];
		vb = regValue[b];
		vc = regValue[c];
		case (op)
			OP_MAC: r = va * vb + vc;
			OP_MUL: r = va * vb;
			default: r = va + vb;
		endcase
		return r;
	endfunction

	function automatic logic anyPending();
		for (int i = 0; i < 16; i++) begin
			if (pending[i])
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// Only ids with no result outstanding may be reused
	function automatic robNdx_t freeId();
		robNdx_t id;
		id = robNdx_t'($urandom % 16);
		while (pending[id])
			id = robNdx_t'($urandom % 16);
		return id;
	endfunction

	function automatic pregno_t randSrc();
		return pregno_t'($urandom % 64);
	endfunction

	// Lanes carry random non-zero registers and always the model value
	task automatic driveBus();
		for (int p = 0; p < NumPorts; p++) begin
			if (busOn) begin
				prn[p] = pregno_t'(1 + $urandom % 63);
				prnv[p] = 1'($urandom & 1);
				rfo[p] = regValue[prn[p]];
			end else begin
				prn[p] = '0;
				prnv[p] = 1'b0;
				rfo[p] = '0;
			end
		end
	endtask

	// Called only while nothing is pending so no capture mixes two phases
	task automatic pickValues();
		regValue[0] = '0;
		for (int r = 1; r < 64; r++)
			regValue[r] = value_t'($urandom);
		driveBus();
	endtask

	task automatic recordOp(input robNdx_t id, input opcode_t op, input pregno_t a,
			input pregno_t b, input pregno_t c, input pregno_t d);
		expValue[id] = calcResult(op, a, b, c);
		expDest[id] = d;
		pending[id] = 1'b1;
		acceptCount++;
	endtask

	task automatic checkResult();
		if (resValid) begin
			assert (pending[resId]) else begin
				errorCount++;
				$display("Result arrived for id %0d which had no operation pending", resId);
			end
			assert (resValue == expValue[resId]) else begin
				errorCount++;
				$display("FAILED resValue id %h: expected %h, got %h",
					resId, expValue[resId], resValue);
			end
			assert (resDest == expDest[resId]) else begin
				errorCount++;
				$display("FAILED resDest id %h: expected %h, got %h",
					resId, expDest[resId], resDest);
			end
			pending[resId] = 1'b0;
			resultCount++;
			doneOrder.push_back(resId);
		end
	endtask

	// One clock with outputs checked and inputs changed on the falling edge
	task automatic stepCycle();
		@(negedge clk);
		checkResult();
		driveBus();
	endtask

	// Holds the operation until a rising edge sees opValid and opReady together
	task automatic sendOp(input robNdx_t id, input opcode_t op, input pregno_t a,
			input pregno_t b, input pregno_t c, input pregno_t d);
		logic took;
		opValid = 1'b1;
		opId = id;
		opOpcode = op;
		opSrcA = a;
		opSrcB = b;
		opSrcC = c;
		opDest = d;
		took = 1'b0;
		while (!took) begin
			took = opReady;
			if (took)
				recordOp(id, op, a, b, c, d);
			stepCycle();
		end
		opValid = 1'b0;
	endtask

	task automatic drainAll();
		while (anyPending())
			stepCycle();
	endtask

	// Upstream operation with only non-zero sources
	task automatic loadOp(input int k);
		opValid = 1'b1;
		opId = robNdx_t'(k);
		opOpcode = opcode_t'(k % 3);
		opSrcA = pregno_t'(1 + $urandom % 63);
		opSrcB = pregno_t'(1 + $urandom % 63);
		opSrcC = pregno_t'(1 + $urandom % 63);
		opDest = randSrc();
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		logic took;
		robNdx_t idX;
		robNdx_t idY;
		seed = $urandom(32'h6197);
		clk = 1'b0;
		rst = 1'b1;
		opValid = 1'b0;
		opId = '0;
		opOpcode = OP_MAC;
		opSrcA = '0;
		opSrcB = '0;
		opSrcC = '0;
		opDest = '0;
		busOn = 1'b0;
		errorCount = 0;
		resultCount = 0;
		acceptCount = 0;
		cycleCount = 0;
		for (int i = 0; i < 16; i++)
			pending[i] = 1'b0;
		pickValues();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		assert (opReady) else begin
			errorCount++;
			$display("FAILED opReady after reset: expected 1, got %h", opReady);
		end

		// With an idle bus exactly StationDepth operations fit before opReady falls
		loadOp(0);
		repeat (StationDepth + 4) begin
			took = opReady;
			if (took)
				recordOp(opId, opOpcode, opSrcA, opSrcB, opSrcC, opDest);
			stepCycle();
			if (took)
				loadOp(acceptCount);
		end
		assert (acceptCount == StationDepth) else begin
			errorCount++;
			$display("FAILED accepted count: expected %h, got %h", StationDepth, acceptCount);
		end

		// The next operation stays on the inputs while the station is full
		repeat (10) begin
			assert (!opReady) else begin
				errorCount++;
				$display("FAILED opReady while full: expected 0, got %h", opReady);
			end
			stepCycle();
		end
		assert (resultCount == 0) else begin
			errorCount++;
			$display("A result came out while every source was still waiting on the bus");
		end

		// Bus traffic frees an entry and the held operation goes in
		busOn = 1'b1;
		sendOp(opId, opOpcode, opSrcA, opSrcB, opSrcC, opDest);
		drainAll();
		assert (resultCount == StationDepth + 1) else begin
			errorCount++;
			$display("FAILED resultCount: expected %h, got %h", StationDepth + 1, resultCount);
		end

		// Register-0 sources need no bus and every opcode then gives zero
		busOn = 1'b0;
		driveBus();
		for (int k = 0; k < 6; k++)
			sendOp(freeId(), opcode_t'(k % 3), '0, '0, '0, randSrc());
		drainAll();

		// A ready operation overtakes one still waiting on register 5
		pickValues();
		doneOrder.delete();
		idX = freeId();
		sendOp(idX, OP_ADD, pregno_t'(5), '0, '0, randSrc());
		idY = freeId();
		sendOp(idY, OP_MUL, '0, '0, '0, randSrc());
		// The ready one gets a bounded window while register 5 stays off the bus
		for (int w = 0; w < 20 && pending[idY]; w++)
			stepCycle();
		busOn = 1'b1;
		drainAll();
		assert (doneOrder.size() == 2 && doneOrder[0] == idY && doneOrder[1] == idX) else begin
			errorCount++;
			$display("Results came out of order: the register-0 operation did not finish first");
		end

		// Main random phase with new register values every hundred operations
		for (int n = 0; n < NumOps; n++) begin
			if (n % 100 == 0) begin
				drainAll();
				pickValues();
			end
			sendOp(freeId(), opcode_t'($urandom % 3), randSrc(), randSrc(), randSrc(), randSrc());
			if ($urandom % 4 == 0)
				stepCycle();
		end
		drainAll();
		assert (resultCount == acceptCount) else begin
			errorCount++;
			$display("FAILED resultCount: expected %h, got %h", acceptCount, resultCount);
		end

		$display("Errors: %0d, results: %0d, accepted: %0d", errorCount, resultCount, acceptCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== files.f ====
stationPkg.sv
opLink.sv
issueLink.sv
opDispatch.sv
operandStation.sv
macExec.sv
issueTop.sv
issueTb.sv

// ==== Makefile ====
# Verilator build and run for the issue subsystem testbench

VERILATOR ?= verilator
TOP ?= issueTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
